//--- vlog.f
+incdir+common
common/csr_index_pkg.sv
common/index_step_if.sv
common/request_push_if.sv
index_generator/index_stepper.sv
index_generator/request_fifo.sv
index_generator/index_sequencer.sv
source/csr_index_generator.sv
bench/csr_index_props.sv
bench/tb_csr_index_generator.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and decides pass or fail from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f vlog.f \
        --top-module tb_csr_index_generator -o tb_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_sim > "$LOG" 2>&1; then
    echo "Simulation exited with an error, see $LOG"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see $LOG"
exit 1

//--- bench/tb_csr_index_generator.sv
// Self-checking testbench that runs directed and random configurations through the CSR index generator
`timescale 1ns/1ps
`default_nettype none

`include "csr_index_consts.svh"

module tb_csr_index_generator;

    localparam int NUM_TESTS   = 8;
    localparam int CYCLE_LIMIT = NUM_TESTS * (64 * 10 + 100);

    logic                    ap_clk;
    logic                    areset;
    logic                    descriptor_valid;
    logic                    config_valid;
    logic [`CSR_ADDR_W-1:0]  config_array_pointer;
    logic [`CSR_INDEX_W-1:0] config_index_start;
    logic [`CSR_INDEX_W-1:0] config_index_end;
    logic [`CSR_INDEX_W-1:0] config_stride;
    logic                    config_decrement;
    logic [`CSR_SHIFT_W-1:0] config_shift_amount;
    logic                    config_shift_left;
    logic                    request_rd_en;
    logic                    config_setup;
    logic                    request_valid;
    logic [`CSR_ADDR_W-1:0]  request_base;
    logic [`CSR_INDEX_W-1:0] request_offset;
    logic                    fifo_setup;
    logic                    done;

    logic [15:0]             lfsr_state;
    logic [`CSR_ADDR_W-1:0]  exp_base [$];
    logic [`CSR_INDEX_W-1:0] exp_offset [$];
    int                      value_errors;
    int                      other_errors;
    int                      checks;
    int                      popped;
    int                      cycles;
    logic                    done_seen = 1'b0;

    csr_index_generator u_csr_index_generator (
        .ap_clk               (ap_clk),
        .areset               (areset),
        .descriptor_valid     (descriptor_valid),
        .config_valid         (config_valid),
        .config_array_pointer (config_array_pointer),
        .config_index_start   (config_index_start),
        .config_index_end     (config_index_end),
        .config_stride        (config_stride),
        .config_decrement     (config_decrement),
        .config_shift_amount  (config_shift_amount),
        .config_shift_left    (config_shift_left),
        .request_rd_en        (request_rd_en),
        .config_setup         (config_setup),
        .request_valid        (request_valid),
        .request_base         (request_base),
        .request_offset       (request_offset),
        .fifo_setup           (fifo_setup),
        .done                 (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // ----------------------------------------
    // Random source and reference model
    // ----------------------------------------
    // 16-bit Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
    function automatic logic [63:0] draw_bits(input int width);
        logic [63:0] value;
        logic        feedback;
        int          i;
        value = '0;
        for (i = 0; i < width; i++) begin
            feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value      = {value[62:0], feedback};
        end
        return value;
    endfunction

    // Walk from start toward end and queue one request per index
    function automatic void build_expected(
        input logic [`CSR_ADDR_W-1:0]  pointer,
        input logic [`CSR_INDEX_W-1:0] start_idx,
        input logic [`CSR_INDEX_W-1:0] end_idx,
        input logic [`CSR_INDEX_W-1:0] stride,
        input logic                    decrement,
        input logic [`CSR_SHIFT_W-1:0] shift_amount,
        input logic                    shift_left
    );
        longint      idx;
        logic [63:0] shifted;
        idx = longint'(start_idx);
        while (decrement ? (idx > longint'(end_idx)) : (idx < longint'(end_idx))) begin
            shifted = shift_left ? (idx << shift_amount) : (idx >> shift_amount);
            exp_base.push_back(pointer);
            exp_offset.push_back(shifted[`CSR_INDEX_W-1:0]);
            idx = decrement ? idx - longint'(stride) : idx + longint'(stride);
        end
    endfunction

    // ----------------------------------------
    // Checker
    // ----------------------------------------
    always @(negedge ap_clk) begin
        if (areset) begin
            done_seen = 1'b0;
        end else begin
            if (request_valid) begin
                if (exp_base.size() == 0) begin
                    $display("Request popped with no request left in the expected list");
                    other_errors++;
                end else begin
                    checks++;
                    assert (request_base == exp_base[0]) else begin
                        $display("ERROR request_base: got %h, expected %h",
                                 request_base, exp_base[0]);
                        value_errors++;
                    end
                    assert (request_offset == exp_offset[0]) else begin
                        $display("ERROR request_offset: got %h, expected %h",
                                 request_offset, exp_offset[0]);
                        value_errors++;
                    end
                    void'(exp_base.pop_front());
                    void'(exp_offset.pop_front());
                    popped++;
                end
            end
            assert (!(done && exp_base.size() != 0)) else begin
                $display("done rose while %0d expected requests were still missing",
                         exp_base.size());
                other_errors++;
            end
            assert (!(done_seen && !done)) else begin
                $display("done fell again without a reset");
                other_errors++;
            end
            if (done) begin
                done_seen = 1'b1;
            end
        end
    end

    always @(posedge ap_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles before all tests finished", cycles);
            $display("Checks %0d, value errors %0d, other errors %0d",
                     checks, value_errors, other_errors);
            $display("Done: errors found");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    // Holds reset over two rising edges and returns once the FIFO setup window is over
    task automatic reset_dut();
        int wait_cycles;
        areset           = 1'b1;
        descriptor_valid = 1'b0;
        config_valid     = 1'b0;
        request_rd_en    = 1'b0;
        repeat (2) @(posedge ap_clk);
        @(negedge ap_clk);
        areset = 1'b0;
        assert (!done && !request_valid && !config_setup && fifo_setup) else begin
            $display("ERROR reset: done %h request_valid %h config_setup %h fifo_setup %h",
                     done, request_valid, config_setup, fifo_setup);
            value_errors++;
        end
        wait_cycles = 0;
        while (fifo_setup && wait_cycles < `CSR_SETUP_CYCLES + 1) begin
            @(negedge ap_clk);
            wait_cycles++;
        end
        assert (!fifo_setup) else begin
            $display("fifo_setup still high %0d cycles after reset", wait_cycles);
            other_errors++;
        end
    endtask

    // Tests 0 and 1 walk a full range up and down and test 2 has an empty range
    task automatic run_test(input int test_idx);
        logic [`CSR_INDEX_W-1:0] span;
        int                      delay;
        int                      gap;
        int                      expected_total;
        config_array_pointer = draw_bits(64);
        config_stride        = 32'(draw_bits(2) + 64'd1);
        config_shift_amount  = 5'(draw_bits(5));
        config_shift_left    = 1'(draw_bits(1));
        config_decrement     = (test_idx < 2) ? (test_idx == 1) : 1'(draw_bits(1));
        config_index_start   = 32'(draw_bits(8) + 64'd100);
        span = (test_idx == 2) ? 32'd0 : ((test_idx < 2) ? 32'd63 : 32'(draw_bits(6)));
        config_index_end = config_decrement ? config_index_start - span
                                            : config_index_start + span;
        descriptor_valid = 1'b1;
        @(negedge ap_clk);
        descriptor_valid = 1'b0;
        while (!config_setup) begin
            @(negedge ap_clk);
        end
        delay = int'(draw_bits(2));
        repeat (delay) @(negedge ap_clk);
        popped = 0;
        build_expected(config_array_pointer, config_index_start, config_index_end,
                       config_stride, config_decrement, config_shift_amount,
                       config_shift_left);
        expected_total = exp_base.size();
        config_valid   = 1'b1;
        @(negedge ap_clk);
        config_valid = 1'b0;
        // Long initial hold so the FIFO reaches its threshold
        gap = 20;
        while (!done) begin
            if (gap > 0) begin
                request_rd_en = 1'b0;
                gap--;
            end else begin
                request_rd_en = 1'b1;
                if (draw_bits(3) == 64'd0) begin
                    gap = 8 + int'(draw_bits(4));
                end
            end
            @(negedge ap_clk);
        end
        // Extra pops must find the FIFO empty
        request_rd_en = 1'b1;
        repeat (4) @(negedge ap_clk);
        request_rd_en = 1'b0;
        assert (popped == expected_total) else begin
            $display("ERROR popped count: got %h, expected %h", popped, expected_total);
            value_errors++;
        end
    endtask

    initial begin
        int test_idx;
        lfsr_state           = 16'd20110;
        value_errors         = 0;
        other_errors         = 0;
        checks               = 0;
        popped               = 0;
        cycles               = 0;
        config_array_pointer = '0;
        config_index_start   = '0;
        config_index_end     = '0;
        config_stride        = '0;
        config_decrement     = 1'b0;
        config_shift_amount  = '0;
        config_shift_left    = 1'b0;
        for (test_idx = 0; test_idx < NUM_TESTS; test_idx++) begin
            reset_dut();
            run_test(test_idx);
        end
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_csr_index_generator

`default_nettype wire

//--- bench/csr_index_props.sv
// Protocol properties of the CSR index generator, bound onto the top level
`timescale 1ns/1ps
`default_nettype none

module csr_index_props (
    input logic ap_clk,
    input logic areset,
    input logic request_rd_en,
    input logic request_valid,
    input logic config_setup,
    input logic done
);

    // ----------------------------------------
    // Read port, setup pulse and done level
    // ----------------------------------------
    // Read data only one cycle after a pop
    property valid_after_rd_en;
        @(posedge ap_clk) disable iff (areset)
            request_valid |-> $past(request_rd_en);
    endproperty

    // Done is terminal until the next reset
    property done_sticky;
        @(posedge ap_clk) disable iff (areset)
            done |=> done;
    endproperty

    property setup_single_pulse;
        @(posedge ap_clk) disable iff (areset)
            config_setup |=> !config_setup;
    endproperty

    assert property (valid_after_rd_en)
        else $error("request_valid without request_rd_en in the cycle before");
    assert property (done_sticky)
        else $error("done fell while reset was low");
    assert property (setup_single_pulse)
        else $error("config_setup stayed high for more than one cycle");

endmodule : csr_index_props

bind csr_index_generator csr_index_props u_csr_index_props (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .request_rd_en (request_rd_en),
    .request_valid (request_valid),
    .config_setup  (config_setup),
    .done          (done)
);

`default_nettype wire

//--- source/csr_index_generator.sv
// Top level of the CSR neighbor index generator with plain ports around sequencer, stepper and FIFO
`timescale 1ns/1ps
`default_nettype none

`include "csr_index_consts.svh"

module csr_index_generator (
    input  logic                    ap_clk,
    input  logic                    areset,
    input  logic                    descriptor_valid,
    input  logic                    config_valid,
    input  logic [`CSR_ADDR_W-1:0]  config_array_pointer,
    input  logic [`CSR_INDEX_W-1:0] config_index_start,
    input  logic [`CSR_INDEX_W-1:0] config_index_end,
    input  logic [`CSR_INDEX_W-1:0] config_stride,
    input  logic                    config_decrement,
    input  logic [`CSR_SHIFT_W-1:0] config_shift_amount,
    input  logic                    config_shift_left,
    input  logic                    request_rd_en,
    output logic                    config_setup,
    output logic                    request_valid,
    output logic [`CSR_ADDR_W-1:0]  request_base,
    output logic [`CSR_INDEX_W-1:0] request_offset,
    output logic                    fifo_setup,
    output logic                    done
);

    import csr_index_pkg::*;

    index_config_t run_config;
    request_t      fifo_rd_data;

    index_step_if   step_bus ();
    request_push_if push_bus ();

    // Configuration word from the plain ports
    assign run_config.array_pointer = config_array_pointer;
    assign run_config.index_start   = config_index_start;
    assign run_config.index_end     = config_index_end;
    assign run_config.stride        = config_stride;
    assign run_config.decrement     = config_decrement;
    assign run_config.shift_amount  = config_shift_amount;
    assign run_config.shift_left    = config_shift_left;

    // -------------------------------------
    // Generator blocks
    // -------------------------------------
    index_sequencer u_index_sequencer (
        .ap_clk           (ap_clk),
        .areset           (areset),
        .descriptor_valid (descriptor_valid),
        .config_valid     (config_valid),
        .run_config       (run_config),
        .config_setup     (config_setup),
        .step             (step_bus),
        .push_port        (push_bus),
        .done             (done)
    );

    index_stepper u_index_stepper (
        .ap_clk (ap_clk),
        .areset (areset),
        .step   (step_bus)
    );

    request_fifo u_request_fifo (
        .ap_clk    (ap_clk),
        .areset    (areset),
        .push_port (push_bus),
        .rd_en     (request_rd_en),
        .rd_valid  (request_valid),
        .rd_data   (fifo_rd_data)
    );

    assign request_base   = fifo_rd_data.base;
    assign request_offset = fifo_rd_data.offset;
    assign fifo_setup     = push_bus.setup_busy;

endmodule : csr_index_generator

`default_nettype wire

//--- index_generator/index_sequencer.sv
// Run control for the index generator that captures one configuration and pushes one request per index
`timescale 1ns/1ps
`default_nettype none

`include "csr_index_consts.svh"

module index_sequencer (
    input  logic                         ap_clk,
    input  logic                         areset,
    input  logic                         descriptor_valid,
    input  logic                         config_valid,
    input  csr_index_pkg::index_config_t run_config,
    output logic                         config_setup,
    index_step_if.master                 step,
    request_push_if.master               push_port,
    output logic                         done
);

    import csr_index_pkg::*;

    typedef enum logic [3:0] {
        S_RESET,
        S_IDLE,
        S_SETUP_REQ,
        S_SETUP,
        S_START_TRANS,
        S_START,
        S_BUSY,
        S_PAUSE,
        S_DONE_TRANS,
        S_DONE
    } seq_state_t;

    seq_state_t    state;
    seq_state_t    next_state;
    logic          descriptor_reg;
    index_config_t config_reg;
    request_t      request_next;
    logic          issue;

    // -------------------------------------
    // Descriptor and configuration capture
    // -------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            descriptor_reg <= 1'b0;
        end else begin
            descriptor_reg <= descriptor_valid;
        end
    end

    // First config_valid seen while waiting in setup
    always_ff @(posedge ap_clk) begin
        if (state == S_SETUP && config_valid) begin
            config_reg <= run_config;
        end
    end

    // -------------------------------------
    // Run state machine
    // -------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            state <= S_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_RESET:       next_state = S_IDLE;
            S_IDLE:        if (descriptor_reg) next_state = S_SETUP_REQ;
            S_SETUP_REQ:   next_state = S_SETUP;
            S_SETUP:       if (config_valid) next_state = S_START_TRANS;
            S_START_TRANS: next_state = S_START;
            // Hold off until the FIFO accepts writes
            S_START:       if (!push_port.setup_busy) next_state = S_BUSY;
            S_BUSY: begin
                if (step.at_end) begin
                    next_state = S_DONE_TRANS;
                end else if (push_port.prog_full) begin
                    next_state = S_PAUSE;
                end
            end
            S_PAUSE:       if (!push_port.prog_full) next_state = S_BUSY;
            // Consumer has drained every pushed request
            S_DONE_TRANS:  if (push_port.empty) next_state = S_DONE;
            S_DONE:        next_state = S_DONE;
            default:       next_state = S_RESET;
        endcase
    end

    // One setup pulse per run and a sticky done
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            config_setup <= 1'b0;
            done         <= 1'b0;
        end else begin
            config_setup <= (state == S_SETUP_REQ);
            if (state == S_DONE) begin
                done <= 1'b1;
            end
        end
    end

    // -------------------------------------
    // Index stepper control
    // -------------------------------------
    assign issue = (state == S_BUSY) && !step.at_end && !push_port.prog_full;

    assign step.load       = (state == S_START_TRANS);
    assign step.step       = issue;
    assign step.load_value = config_reg.index_start;
    assign step.stride     = config_reg.stride;
    assign step.decrement  = config_reg.decrement;
    assign step.index_end  = config_reg.index_end;

    // -------------------------------------
    // Request formation and push
    // -------------------------------------
    always_comb begin
        request_next.base = config_reg.array_pointer;
        if (config_reg.shift_left) begin
            request_next.offset = step.count << config_reg.shift_amount;
        end else begin
            request_next.offset = step.count >> config_reg.shift_amount;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset) begin
            push_port.push <= 1'b0;
        end else begin
            push_port.push <= issue;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (issue) begin
            push_port.push_data <= request_next;
        end
    end

endmodule : index_sequencer

`default_nettype wire

//--- index_generator/request_fifo.sv
// Synchronous request FIFO with a programmable-full level and a setup-busy window after reset
`timescale 1ns/1ps
`default_nettype none

`include "csr_index_consts.svh"

module request_fifo (
    input  logic                   ap_clk,
    input  logic                   areset,
    request_push_if.fifo           push_port,
    input  logic                   rd_en,
    output logic                   rd_valid,
    output csr_index_pkg::request_t rd_data
);

    import csr_index_pkg::*;

    localparam int PTR_W   = $clog2(`CSR_FIFO_DEPTH);
    localparam int FILL_W  = $clog2(`CSR_FIFO_DEPTH + 1);
    localparam int SETUP_W = $clog2(`CSR_SETUP_CYCLES + 1);

    request_t           mem [`CSR_FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [FILL_W-1:0]  fill;
    logic [SETUP_W-1:0] setup_cnt;
    logic               setup_busy_reg;
    logic               do_write;
    logic               do_read;

    assign do_write = push_port.push && !setup_busy_reg;
    assign do_read  = rd_en && (fill != '0);

    // -------------------------------------
    // Setup window after reset
    // -------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            setup_cnt      <= SETUP_W'(`CSR_SETUP_CYCLES);
            setup_busy_reg <= 1'b1;
        end else if (setup_cnt != '0) begin
            setup_cnt      <= setup_cnt - 1'b1;
            setup_busy_reg <= (setup_cnt != SETUP_W'(1));
        end
    end

    // -------------------------------------
    // Pointers and fill level
    // -------------------------------------
    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_write) wr_ptr <= wr_ptr + 1'b1;
            if (do_read)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= push_port.push_data;
        end
    end

    // -------------------------------------
    // Read port, data one cycle after pop
    // -------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= do_read;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (do_read) begin
            rd_data <= mem[rd_ptr];
        end
    end

    assign push_port.prog_full  = (fill >= FILL_W'(`CSR_PROG_THRESH));
    assign push_port.empty      = (fill == '0);
    assign push_port.setup_busy = setup_busy_reg;

endmodule : request_fifo

`default_nettype wire

//--- index_generator/index_stepper.sv
// Index counter walking from the loaded start by a stride, flags the end of the range
`timescale 1ns/1ps
`default_nettype none

`include "csr_index_consts.svh"

module index_stepper (
    input  logic          ap_clk,
    input  logic          areset,
    index_step_if.stepper step
);

    logic [`CSR_INDEX_W-1:0] count_reg;
    logic [`CSR_INDEX_W-1:0] step_delta;

    // Stride as a two's complement delta, negated for a downward walk
    assign step_delta = step.decrement ? -step.stride : step.stride;

    // -------------------------------------
    // Count register
    // -------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            count_reg <= '0;
        end else if (step.load) begin
            count_reg <= step.load_value;
        end else if (step.step) begin
            count_reg <= count_reg + step_delta;
        end
    end

    assign step.count = count_reg;

    // -------------------------------------
    // End of range
    // -------------------------------------
    // Upward walk ends at or past index_end, downward at or below it
    always_comb begin
        if (step.decrement) begin
            step.at_end = (count_reg <= step.index_end);
        end else begin
            step.at_end = (count_reg >= step.index_end);
        end
    end

endmodule : index_stepper

`default_nettype wire

//--- common/request_push_if.sv
// Push side of the request FIFO, the sequencer takes the master modport
`timescale 1ns/1ps
`default_nettype none

`include "csr_index_consts.svh"

interface request_push_if;

    import csr_index_pkg::*;

    // Write side
    logic     push;
    request_t push_data;

    // FIFO status back to the producer
    logic prog_full;
    logic empty;
    logic setup_busy;

    modport master (
        output push, push_data,
        input  prog_full, empty, setup_busy
    );

    modport fifo (
        input  push, push_data,
        output prog_full, empty, setup_busy
    );

endinterface : request_push_if

`default_nettype wire

//--- common/index_step_if.sv
// Sequencer to index stepper link, connect the master side to the sequencer
`timescale 1ns/1ps
`default_nettype none

`include "csr_index_consts.svh"

interface index_step_if;

    // Controls from the sequencer
    logic                    load;
    logic                    step;
    logic [`CSR_INDEX_W-1:0] load_value;
    logic [`CSR_INDEX_W-1:0] stride;
    logic                    decrement;
    logic [`CSR_INDEX_W-1:0] index_end;

    // Stepper state
    logic [`CSR_INDEX_W-1:0] count;
    logic                    at_end;

    modport master (
        output load, step, load_value, stride, decrement, index_end,
        input  count, at_end
    );

    modport stepper (
        input  load, step, load_value, stride, decrement, index_end,
        output count, at_end
    );

endinterface : index_step_if

`default_nettype wire

//--- common/csr_index_pkg.sv
// Configuration and request types used across the CSR index generator, import where needed
`default_nettype none

`include "csr_index_consts.svh"

package csr_index_pkg;

    // -------------------------------------
    // Run configuration
    // -------------------------------------
    typedef struct packed {
        logic [`CSR_ADDR_W-1:0]  array_pointer;
        logic [`CSR_INDEX_W-1:0] index_start;
        logic [`CSR_INDEX_W-1:0] index_end;
        logic [`CSR_INDEX_W-1:0] stride;
        // Walk downward from index_start
        logic                    decrement;
        logic [`CSR_SHIFT_W-1:0] shift_amount;
        // Offset is index << amount when set, index >> amount otherwise
        logic                    shift_left;
    } index_config_t;

    // -------------------------------------
    // Memory request
    // -------------------------------------
    typedef struct packed {
        logic [`CSR_ADDR_W-1:0]  base;
        logic [`CSR_INDEX_W-1:0] offset;
    } request_t;

endpackage : csr_index_pkg

`default_nettype wire

//--- common/csr_index_consts.svh
// Width, depth and timing constants shared by the CSR index generator RTL and its testbench
`ifndef CSR_INDEX_CONSTS_SVH
`define CSR_INDEX_CONSTS_SVH

// Index, offset and stride width
`define CSR_INDEX_W 32

// Array pointer and request base width
`define CSR_ADDR_W 64

// Shift amount applied to the index
`define CSR_SHIFT_W 5

// Request FIFO sizing
`define CSR_FIFO_DEPTH 16
`define CSR_PROG_THRESH 8

// FIFO busy time after reset is released
`define CSR_SETUP_CYCLES 4

`endif
